/* hdl/cpu_profile_pkg.sv */
`default_nettype none

package cpu_profile_pkg;

  // machine width of the integer datapath for rv32.
  localparam int unsigned XLEN = 32;

  // enough bits to hold any shift amount for XLEN.
  localparam int unsigned SHAMT_W = $clog2(XLEN);

endpackage

`default_nettype wire

/* hdl/decode_pkg.sv */
`default_nettype none

package decode_pkg;
  import cpu_profile_pkg::*;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA
  } alu_op_e;

  typedef enum logic [1:0] {
    id2ex_buf,   // value read by decode from the register file.
    mem_forward, // newest result in the history.
    wb_forward   // the result before that.
  } alu_data_sel_e;

  typedef enum logic {
    src1_rs1,
    src1_pc
  } alu_src1_sel_e;

  typedef enum logic {
    src2_rs2,
    src2_imm
  } alu_src2_sel_e;

  typedef enum logic [2:0] {
    CMP_NONE,
    CMP_EQ,
    CMP_NE,
    CMP_LT,
    CMP_GE,
    CMP_LTU,
    CMP_GEU
  } cmp_op_e;

  typedef enum logic {
    JB_PC,
    JB_ALU
  } jump_base_sel_e;

  // one decoded micro-op as handed over by decode.
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] imm;
    alu_op_e         alu_op;
    alu_data_sel_e   rs1_sel;
    alu_data_sel_e   rs2_sel;
    alu_src1_sel_e   src1_sel;
    alu_src2_sel_e   src2_sel;
    cmp_op_e         cmp_op;
    jump_base_sel_e  jump_base_sel;
  } ex_cmd_t;

  typedef struct packed {
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] mem_wdata;
    logic [XLEN-1:0] pc_target;
    logic            branch_taken;
  } ex_result_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_EXEC,
    ST_SHIFT,
    ST_DONE
  } ex_state_e;

endpackage

`default_nettype wire

/* hdl/ex_alu.sv */
`default_nettype none

module ex_alu
  import cpu_profile_pkg::*;
  import decode_pkg::*;
(
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  alu_op_e         alu_op_i,
  input  logic [XLEN-1:0] src1_i,
  input  logic [XLEN-1:0] src2_i,
  input  logic            shift_load_i,
  input  logic            shift_step_i,
  output logic [XLEN-1:0] alu_result_o
);

  logic [XLEN-1:0] shift_q;

  // one bit position per step, direction taken from the opcode.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      shift_q <= '0;
    end else if (shift_load_i) begin
      shift_q <= src1_i;
    end else if (shift_step_i) begin
      unique case (alu_op_i)
        ALU_SLL: shift_q <= {shift_q[XLEN-2:0], 1'b0};
        ALU_SRA: shift_q <= {shift_q[XLEN-1], shift_q[XLEN-1:1]}; // keeps the sign bit.
        default: shift_q <= {1'b0, shift_q[XLEN-1:1]};
      endcase
    end
  end

  always_comb begin
    unique case (alu_op_i)
      ALU_ADD:  alu_result_o = src1_i + src2_i;
      ALU_SUB:  alu_result_o = src1_i - src2_i;
      ALU_AND:  alu_result_o = src1_i & src2_i;
      ALU_OR:   alu_result_o = src1_i | src2_i;
      ALU_XOR:  alu_result_o = src1_i ^ src2_i;
      ALU_SLT:  alu_result_o = {{(XLEN-1){1'b0}}, $signed(src1_i) < $signed(src2_i)};
      ALU_SLTU: alu_result_o = {{(XLEN-1){1'b0}}, src1_i < src2_i};
      ALU_SLL,
      ALU_SRL,
      ALU_SRA:  alu_result_o = shift_q;
      default:  alu_result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/ex_cmp.sv */
`default_nettype none

module ex_cmp
  import cpu_profile_pkg::*;
  import decode_pkg::*;
(
  input  cmp_op_e         cmp_op_i,
  input  logic [XLEN-1:0] data1_i,
  input  logic [XLEN-1:0] data2_i,
  output logic            branch_taken_o
);

  logic eq;
  logic lt_s;
  logic lt_u;

  assign eq   = (data1_i == data2_i);
  assign lt_s = ($signed(data1_i) < $signed(data2_i));
  assign lt_u = (data1_i < data2_i);

  always_comb begin
    unique case (cmp_op_i)
      CMP_EQ:  branch_taken_o = eq;
      CMP_NE:  branch_taken_o = !eq;
      CMP_LT:  branch_taken_o = lt_s;
      CMP_GE:  branch_taken_o = !lt_s;
      CMP_LTU: branch_taken_o = lt_u;
      CMP_GEU: branch_taken_o = !lt_u;
      default: branch_taken_o = 1'b0; // not a branch.
    endcase
  end

endmodule

`default_nettype wire

/* hdl/ex_ctrl_fsm.sv */
`default_nettype none

module ex_ctrl_fsm
  import decode_pkg::*;
(
  input  logic    clk_i,
  input  logic    arst_n_i,
  input  logic    req_i,
  input  ex_cmd_t cmd_i,
  input  logic    shift_done_i,
  output ex_cmd_t cmd_q_o,
  output logic    shift_load_o,
  output logic    shift_step_o,
  output logic    res_we_o,
  output logic    ack_o
);

  ex_state_e state_q;
  ex_state_e state_d;
  ex_cmd_t   cmd_q;
  logic      cap_en;
  logic      is_shift;

  assign is_shift = (cmd_q.alu_op == ALU_SLL) ||
                    (cmd_q.alu_op == ALU_SRL) ||
                    (cmd_q.alu_op == ALU_SRA);

  always_comb begin
    state_d      = state_q;
    cap_en       = 1'b0;
    shift_load_o = 1'b0;
    shift_step_o = 1'b0;
    res_we_o     = 1'b0;
    unique case (state_q)
      ST_IDLE: begin
        if (req_i) begin
          cap_en  = 1'b1;
          state_d = ST_EXEC;
        end
      end
      ST_EXEC: begin
        if (is_shift) begin
          shift_load_o = 1'b1; // shifter takes src1, counter takes the amount.
          state_d      = ST_SHIFT;
        end else begin
          res_we_o = 1'b1;
          state_d  = ST_DONE;
        end
      end
      ST_SHIFT: begin
        if (shift_done_i) begin
          res_we_o = 1'b1;
          state_d  = ST_DONE;
        end else begin
          shift_step_o = 1'b1;
        end
      end
      ST_DONE: begin
        if (!req_i) begin
          state_d = ST_IDLE; // producer has seen ack.
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cap_en) begin
      cmd_q <= cmd_i;
    end
  end

  assign cmd_q_o = cmd_q;
  assign ack_o   = (state_q == ST_DONE); // held until req_i drops.

endmodule

`default_nettype wire

/* hdl/ex_operand_sel.sv */
`default_nettype none

module ex_operand_sel
  import cpu_profile_pkg::*;
  import decode_pkg::*;
(
  input  ex_cmd_t         cmd_i,
  input  logic [XLEN-1:0] mem_fwd_i,
  input  logic [XLEN-1:0] wb_fwd_i,
  output logic [XLEN-1:0] rs2_data_o,
  output logic [XLEN-1:0] src1_o,
  output logic [XLEN-1:0] src2_o
);

  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;

  always_comb begin
    unique case (cmd_i.rs1_sel)
      id2ex_buf:   rs1_data = cmd_i.rs1_data;
      mem_forward: rs1_data = mem_fwd_i;
      wb_forward:  rs1_data = wb_fwd_i;
      default:     rs1_data = '0; // encoding 3 is never issued.
    endcase
  end

  always_comb begin
    unique case (cmd_i.rs2_sel)
      id2ex_buf:   rs2_data = cmd_i.rs2_data;
      mem_forward: rs2_data = mem_fwd_i;
      wb_forward:  rs2_data = wb_fwd_i;
      default:     rs2_data = '0;
    endcase
  end

  assign rs2_data_o = rs2_data; // store data follows the forwarded rs2.

  always_comb begin
    unique case (cmd_i.src1_sel)
      src1_rs1: src1_o = rs1_data;
      src1_pc:  src1_o = cmd_i.pc; // auipc and jal style operand.
    endcase
  end

  always_comb begin
    unique case (cmd_i.src2_sel)
      src2_rs2: src2_o = rs2_data;
      src2_imm: src2_o = cmd_i.imm;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/ex_result_regs.sv */
`default_nettype none

module ex_result_regs
  import cpu_profile_pkg::*;
  import decode_pkg::*;
(
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            we_i,
  input  ex_result_t      result_i,
  output ex_result_t      result_o,
  output logic [XLEN-1:0] mem_fwd_o,
  output logic [XLEN-1:0] wb_fwd_o
);

  ex_result_t      result_q;
  logic [XLEN-1:0] mem_fwd_q;
  logic [XLEN-1:0] wb_fwd_q;

  // each write pushes the history one stage down, as mem moves into wb.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      result_q  <= '0;
      mem_fwd_q <= '0;
      wb_fwd_q  <= '0;
    end else if (we_i) begin
      result_q  <= result_i;
      mem_fwd_q <= result_i.alu_result;
      wb_fwd_q  <= mem_fwd_q;
    end
  end

  assign result_o  = result_q;
  assign mem_fwd_o = mem_fwd_q;
  assign wb_fwd_o  = wb_fwd_q;

endmodule

`default_nettype wire

/* hdl/ex_shift_counter.sv */
`default_nettype none

module ex_shift_counter
  import cpu_profile_pkg::*;
(
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               load_i,
  input  logic [SHAMT_W-1:0] amount_i,
  input  logic               step_i,
  output logic               done_o
);

  logic [SHAMT_W-1:0] count_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= '0;
    end else if (load_i) begin
      count_q <= amount_i;
    end else if (step_i && !done_o) begin
      count_q <= count_q - 1'b1;
    end
  end

  // a zero amount reports done on the first shift cycle.
  assign done_o = (count_q == '0);

endmodule

`default_nettype wire

/* hdl/ex_stage_top.sv */
`default_nettype none

module ex_stage_top
  import cpu_profile_pkg::*;
  import decode_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       req_i,
  input  ex_cmd_t    cmd_i,
  output logic       ack_o,
  output ex_result_t result_o
);

  ex_cmd_t         cmd_q;
  ex_result_t      result_d;
  logic            shift_load;
  logic            shift_step;
  logic            shift_done;
  logic            res_we;
  logic            branch_taken;
  logic [XLEN-1:0] mem_fwd;
  logic [XLEN-1:0] wb_fwd;
  logic [XLEN-1:0] rs2_data;
  logic [XLEN-1:0] src1;
  logic [XLEN-1:0] src2;
  logic [XLEN-1:0] alu_result;

  ex_ctrl_fsm i_ex_ctrl_fsm (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_i       (req_i),
    .cmd_i       (cmd_i),
    .shift_done_i(shift_done),
    .cmd_q_o     (cmd_q),
    .shift_load_o(shift_load),
    .shift_step_o(shift_step),
    .res_we_o    (res_we),
    .ack_o       (ack_o)
  );

  ex_operand_sel i_ex_operand_sel (
    .cmd_i     (cmd_q),
    .mem_fwd_i (mem_fwd),
    .wb_fwd_i  (wb_fwd),
    .rs2_data_o(rs2_data),
    .src1_o    (src1),
    .src2_o    (src2)
  );

  ex_alu i_ex_alu (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .alu_op_i    (cmd_q.alu_op),
    .src1_i      (src1),
    .src2_i      (src2),
    .shift_load_i(shift_load),
    .shift_step_i(shift_step),
    .alu_result_o(alu_result)
  );

  ex_cmp i_ex_cmp (
    .cmp_op_i      (cmd_q.cmp_op),
    .data1_i       (src1),
    .data2_i       (src2),
    .branch_taken_o(branch_taken)
  );

  ex_shift_counter i_ex_shift_counter (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .load_i  (shift_load),
    .amount_i(src2[SHAMT_W-1:0]),
    .step_i  (shift_step),
    .done_o  (shift_done)
  );

  assign result_d.alu_result   = alu_result;
  assign result_d.mem_wdata    = rs2_data;
  assign result_d.branch_taken = branch_taken;
  // jal and branches use pc plus imm, jalr takes the alu sum.
  assign result_d.pc_target    = (cmd_q.jump_base_sel == JB_PC) ? cmd_q.pc + cmd_q.imm
                                                                : alu_result;

  ex_result_regs i_ex_result_regs (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .we_i     (res_we),
    .result_i (result_d),
    .result_o (result_o),
    .mem_fwd_o(mem_fwd),
    .wb_fwd_o (wb_fwd)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the execute stage testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_ex_stage -o sim_ex_stage
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_ex_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Checks failed" "$LOG"; then
  echo "Simulation reported failures"
  exit 1
fi

if ! grep -q "All checks passed" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi

exit 0

/* testbench/tb_ex_stage.sv */
`default_nettype none

module tb_ex_stage
  import cpu_profile_pkg::*;
  import decode_pkg::*;
();

  localparam int TIMEOUT = 100; // the longest shift needs about 35 edges.

  logic       clk_i;
  logic       arst_n_i;
  logic       req_i;
  ex_cmd_t    cmd_i;
  logic       ack_o;
  ex_result_t result_o;

  ex_cmd_t         cmd_tab[$];
  ex_result_t      exp_tab[$];
  logic [XLEN-1:0] mem_h;
  logic [XLEN-1:0] wb_h;
  logic [31:0]     rng;
  int              err_cnt;
  int              chk_cnt;
  logic            timed_out;

  ex_stage_top i_ex_stage_top (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .req_i   (req_i),
    .cmd_i   (cmd_i),
    .ack_o   (ack_o),
    .result_o(result_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function logic [31:0] rand_word();
    rng = xorshift(rng);
    return rng;
  endfunction

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic push_cmd(input alu_op_e op, input alu_data_sel_e r1_sel,
                          input alu_data_sel_e r2_sel, input alu_src1_sel_e s1_sel,
                          input alu_src2_sel_e s2_sel, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b, input logic [XLEN-1:0] imm,
                          input cmp_op_e cmp, input jump_base_sel_e jb);
    ex_cmd_t c;
    c.pc            = 32'h0000_1000 + 32'(cmd_tab.size() * 4);
    c.rs1_data      = a;
    c.rs2_data      = b;
    c.imm           = imm;
    c.alu_op        = op;
    c.rs1_sel       = r1_sel;
    c.rs2_sel       = r2_sel;
    c.src1_sel      = s1_sel;
    c.src2_sel      = s2_sel;
    c.cmp_op        = cmp;
    c.jump_base_sel = jb;
    cmd_tab.push_back(c);
  endtask

  // reference model of one rv32i execute step with its own mem and wb history.
  task automatic model_step(input ex_cmd_t c, output ex_result_t r);
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] s1;
    logic [XLEN-1:0] s2;
    logic [XLEN-1:0] alu;
    logic            lt_s;
    logic            lt_u;
    rs1  = (c.rs1_sel == mem_forward) ? mem_h : (c.rs1_sel == wb_forward) ? wb_h : c.rs1_data;
    rs2  = (c.rs2_sel == mem_forward) ? mem_h : (c.rs2_sel == wb_forward) ? wb_h : c.rs2_data;
    s1   = (c.src1_sel == src1_pc) ? c.pc : rs1;
    s2   = (c.src2_sel == src2_imm) ? c.imm : rs2;
    lt_s = $signed(s1) < $signed(s2);
    lt_u = s1 < s2;
    case (c.alu_op)
      ALU_ADD:  alu = s1 + s2;
      ALU_SUB:  alu = s1 - s2;
      ALU_AND:  alu = s1 & s2;
      ALU_OR:   alu = s1 | s2;
      ALU_XOR:  alu = s1 ^ s2;
      ALU_SLT:  alu = 32'(lt_s);
      ALU_SLTU: alu = 32'(lt_u);
      ALU_SLL:  alu = s1 << s2[4:0];
      ALU_SRL:  alu = s1 >> s2[4:0];
      ALU_SRA:  alu = $signed(s1) >>> s2[4:0];
      default:  alu = '0;
    endcase
    case (c.cmp_op)
      CMP_EQ:  r.branch_taken = (s1 == s2);
      CMP_NE:  r.branch_taken = (s1 != s2);
      CMP_LT:  r.branch_taken = lt_s;
      CMP_GE:  r.branch_taken = !lt_s;
      CMP_LTU: r.branch_taken = lt_u;
      CMP_GEU: r.branch_taken = !lt_u;
      default: r.branch_taken = 1'b0;
    endcase
    r.alu_result = alu;
    r.mem_wdata  = rs2;
    r.pc_target  = (c.jump_base_sel == JB_PC) ? c.pc + c.imm : alu;
    wb_h  = mem_h;
    mem_h = alu;
  endtask

  task automatic build_table();
    alu_op_e    ops[7];
    alu_op_e    sh_ops[3];
    logic [4:0] amts[3];
    int         k;
    ops    = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU};
    sh_ops = '{ALU_SLL, ALU_SRL, ALU_SRA};
    amts   = '{5'd0, 5'd1, 5'd31};
    foreach (ops[n]) begin
      push_cmd(ops[n], id2ex_buf, id2ex_buf, src1_rs1, src2_rs2,
               rand_word(), rand_word(), '0, CMP_NONE, JB_PC);
      push_cmd(ops[n], id2ex_buf, id2ex_buf, src1_rs1, src2_imm,
               rand_word(), '0, rand_word(), CMP_NONE, JB_PC);
    end
    // a negative value is small when signed and large when unsigned.
    push_cmd(ALU_SLT, id2ex_buf, id2ex_buf, src1_rs1, src2_rs2,
             32'hffff_fff0, 32'h0000_0010, '0, CMP_NONE, JB_PC);
    push_cmd(ALU_SLTU, id2ex_buf, id2ex_buf, src1_rs1, src2_rs2,
             32'hffff_fff0, 32'h0000_0010, '0, CMP_NONE, JB_PC);
    push_cmd(ALU_ADD, id2ex_buf, id2ex_buf, src1_pc, src2_imm,
             rand_word(), '0, 32'h0000_0800, CMP_NONE, JB_PC);
    foreach (sh_ops[n]) begin
      foreach (amts[m]) begin
        push_cmd(sh_ops[n], id2ex_buf, id2ex_buf, src1_rs1, src2_imm,
                 rand_word(), '0, 32'(amts[m]), CMP_NONE, JB_PC);
      end
    end
    push_cmd(ALU_SRA, id2ex_buf, id2ex_buf, src1_rs1, src2_rs2,
             32'h8000_0000, 32'hffff_ffe1, '0, CMP_NONE, JB_PC); // only the low bits count.
    for (k = 0; k < 7; k++) begin
      push_cmd(ALU_SUB, id2ex_buf, id2ex_buf, src1_rs1, src2_rs2,
               32'h0000_1234, 32'h0000_1234, 32'h0000_0040, cmp_op_e'(k), JB_PC);
      push_cmd(ALU_SUB, id2ex_buf, id2ex_buf, src1_rs1, src2_rs2,
               32'h0000_0005, 32'hffff_fffd, 32'hffff_ffc0, cmp_op_e'(k), JB_PC);
      push_cmd(ALU_SUB, id2ex_buf, id2ex_buf, src1_rs1, src2_rs2,
               32'hffff_fffd, 32'h0000_0005, 32'h0000_0100, cmp_op_e'(k), JB_ALU);
    end
    push_cmd(ALU_ADD, id2ex_buf, id2ex_buf, src1_rs1, src2_imm,
             32'h0000_2000, '0, 32'h0000_0014, CMP_NONE, JB_ALU); // jalr style target.
    push_cmd(ALU_ADD, id2ex_buf, id2ex_buf, src1_rs1, src2_rs2,
             rand_word(), rand_word(), '0, CMP_NONE, JB_PC);
    push_cmd(ALU_ADD, mem_forward, id2ex_buf, src1_rs1, src2_imm,
             rand_word(), rand_word(), 32'h0000_0010, CMP_NONE, JB_PC);
    push_cmd(ALU_SUB, wb_forward, mem_forward, src1_rs1, src2_rs2,
             rand_word(), rand_word(), '0, CMP_LT, JB_PC);
    push_cmd(ALU_XOR, id2ex_buf, wb_forward, src1_rs1, src2_rs2,
             rand_word(), rand_word(), '0, CMP_NONE, JB_PC);
    push_cmd(ALU_SLL, mem_forward, id2ex_buf, src1_rs1, src2_imm,
             rand_word(), rand_word(), 32'd3, CMP_NONE, JB_PC);
    push_cmd(ALU_OR, mem_forward, wb_forward, src1_rs1, src2_rs2,
             rand_word(), rand_word(), '0, CMP_GEU, JB_ALU);
    push_cmd(ALU_SRA, wb_forward, mem_forward, src1_rs1, src2_rs2,
             rand_word(), rand_word(), '0, CMP_NONE, JB_PC);
  endtask

  task automatic wait_ack(input logic level, output int edges, output logic ok);
    edges = 0;
    ok    = 1'b0;
    while (!ok && edges < TIMEOUT) begin
      @(posedge clk_i);
      @(negedge clk_i);
      edges++;
      ok = (ack_o == level);
    end
  endtask

  task automatic run_entry(input int idx);
    ex_result_t snap;
    int         edges;
    logic       ok;
    @(negedge clk_i);
    cmd_i = cmd_tab[idx];
    req_i = 1'b1;
    wait_ack(1'b1, edges, ok);
    if (!ok) begin
      err_cnt++;
      timed_out = 1'b1;
      $display("Timeout: ack_o never rose for table entry %0d", idx);
      return;
    end
    if (!(cmd_tab[idx].alu_op inside {ALU_SLL, ALU_SRL, ALU_SRA})) begin
      check("ack_o latency", 128'(edges), 128'd2); // two edges from req_i to ack_o.
    end
    check("result_o.alu_result", result_o.alu_result, exp_tab[idx].alu_result);
    check("result_o.mem_wdata", result_o.mem_wdata, exp_tab[idx].mem_wdata);
    check("result_o.pc_target", result_o.pc_target, exp_tab[idx].pc_target);
    check("result_o.branch_taken", result_o.branch_taken, exp_tab[idx].branch_taken);
    snap = result_o;
    repeat (idx % 3) begin
      @(negedge clk_i);
      check("ack_o", ack_o, 1);
      check("result_o", result_o, snap);
    end
    req_i = 1'b0;
    wait_ack(1'b0, edges, ok);
    if (!ok) begin
      err_cnt++;
      timed_out = 1'b1;
      $display("Timeout: ack_o stayed high after req_i dropped on entry %0d", idx);
      return;
    end
    check("result_o", result_o, snap);
  endtask

  initial begin
    ex_result_t r;
    int         idx;
    arst_n_i  = 1'b0;
    req_i     = 1'b0;
    cmd_i     = '0;
    err_cnt   = 0;
    chk_cnt   = 0;
    timed_out = 1'b0;
    mem_h     = '0;
    wb_h      = '0;
    rng       = 32'h28d6_7875;
    build_table();
    foreach (cmd_tab[n]) begin
      model_step(cmd_tab[n], r);
      exp_tab.push_back(r);
    end
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    check("ack_o", ack_o, 0);
    check("result_o", result_o, 0);
    for (idx = 0; idx < cmd_tab.size() && !timed_out; idx++) begin
      run_entry(idx);
    end
    $display("checks run: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0 && !timed_out) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
hdl/cpu_profile_pkg.sv
hdl/decode_pkg.sv
hdl/ex_operand_sel.sv
hdl/ex_alu.sv
hdl/ex_cmp.sv
hdl/ex_shift_counter.sv
hdl/ex_result_regs.sv
hdl/ex_ctrl_fsm.sv
hdl/ex_stage_top.sv
testbench/tb_ex_stage.sv
